// ==== design/dpath_pkg.sv ====
// Shared widths, select encodings and control bundles for the scalar datapath.
// Compile ahead of every design file that imports it.

package dpath_pkg;

  // ------------------------------------------------------------
  // Widths and base types
  // ------------------------------------------------------------

  localparam int unsigned XLEN       = 32;
  localparam int unsigned NUM_REGS   = 32;
  localparam int unsigned REG_ADDR_W = 5;

  typedef logic [XLEN-1:0]       word_t;
  typedef logic [REG_ADDR_W-1:0] reg_addr_t;

  // ------------------------------------------------------------
  // Mux select encodings
  // ------------------------------------------------------------

  // Next PC source
  typedef enum logic [1:0] {
    PC_PLUS4, PC_BRANCH, PC_JUMP, PC_JUMPREG
  } pc_sel_e;

  // Operand 0 source
  typedef enum logic [1:0] {
    OP0_RDATA, OP0_PC, OP0_PC_PLUS4, OP0_ZERO
  } op0_sel_e;

  // Operand 1 source
  typedef enum logic [2:0] {
    OP1_RDATA, OP1_SHAMT, OP1_IMM_U, OP1_IMM_SB, OP1_IMM_I, OP1_IMM_S, OP1_ZERO
  } op1_sel_e;

  // Bypass source, register file or a later stage
  typedef enum logic [2:0] {
    BYP_RF, BYP_X, BYP_M, BYP_X2, BYP_X3, BYP_W
  } byp_sel_e;

  typedef enum logic [3:0] {
    ALU_ADD, ALU_SUB, ALU_SLL, ALU_OR, ALU_SLT, ALU_SLTU,
    ALU_AND, ALU_XOR, ALU_NOR, ALU_SRL, ALU_SRA
  } alu_fn_e;

  // Load subword extension
  typedef enum logic [2:0] {
    LD_W, LD_B, LD_BU, LD_H, LD_HU
  } load_sel_e;

  // ------------------------------------------------------------
  // Control and data bundles
  // ------------------------------------------------------------

  // One hold bit per register stage
  typedef struct packed {
    logic f, d, x, m, x2, x3, w;
  } stall_t;

  typedef struct packed {
    op0_sel_e op0_sel;
    op1_sel_e op1_sel;
    byp_sel_e byp0_sel;
    byp_sel_e byp1_sel;
  } dec_ctrl_t;

  // wb_sel picks execute result (0) or memory (1)
  typedef struct packed {
    load_sel_e load_sel;
    logic      queue_en;
    logic      queue_val;
    logic      wb_sel;
  } mem_ctrl_t;

  typedef struct packed {
    logic      rf_wen;
    reg_addr_t rf_waddr;
  } wb_ctrl_t;

  // Decoded instruction fields
  typedef struct packed {
    reg_addr_t                 rs1;
    reg_addr_t                 rs2;
    logic [$clog2(XLEN)-1:0]   shamt;
    word_t                     i;
    word_t                     s;
    word_t                     sb;
    word_t                     u;
    word_t                     uj;
  } imm_t;

  typedef struct packed {
    logic eq, ne, lt, ltu, ge, geu;
  } branch_cond_t;

  // Results forwarded back to decode
  typedef struct packed {
    word_t x;
    word_t m;
    word_t x2;
    word_t x3;
    word_t w;
  } byp_src_t;

endpackage

// ==== design/inst_fields.sv ====
// Instruction field decoder for the D stage.
// Pulls out register indices and builds the sign-extended immediates.

`timescale 1ns/1ps

module inst_fields import dpath_pkg::*; (
  input  word_t inst,
  output imm_t  fields
);

  always_comb begin
    // Register indices and shift amount
    fields.rs1   = inst[19:15];
    fields.rs2   = inst[24:20];
    fields.shamt = inst[24:20];

    // I-type, 12 bits signed
    fields.i  = {{20{inst[31]}}, inst[31:20]};

    // S-type, split across funct7 and rd slots
    fields.s  = {{20{inst[31]}}, inst[31:25], inst[11:7]};

    // SB-type, halfword aligned
    fields.sb = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};

    // U-type upper 20 bits
    fields.u  = {inst[31:12], 12'b0};

    // UJ-type, halfword aligned
    fields.uj = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};
  end

endmodule

// ==== design/regfile.sv ====
// Scalar register file with two combinational read ports and one write port.
// Register 0 always reads as zero.

`timescale 1ns/1ps

module regfile import dpath_pkg::*; (
  input  logic      clk,
  input  reg_addr_t raddr0,
  output word_t     rdata0,
  input  reg_addr_t raddr1,
  output word_t     rdata1,
  input  logic      wen,
  input  reg_addr_t waddr,
  input  word_t     wdata
);

  word_t regs [NUM_REGS];

  // Write at end of W
  always_ff @(posedge clk) begin
    if (wen) begin
      regs[waddr] <= wdata;
    end
  end

  // Asynchronous reads, x0 hardwired
  assign rdata0 = (raddr0 == '0) ? '0 : regs[raddr0];
  assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];

endmodule

// ==== design/fetch_stage.sv ====
// P and F stages. Picks the next PC, holds the fetch PC and drives the
// instruction memory address ahead of the PC register.

`timescale 1ns/1ps

module fetch_stage import dpath_pkg::*; #(
  parameter word_t RESET_VECTOR = '0
) (
  input  logic    clk,
  input  logic    reset,
  input  pc_sel_e pc_sel,
  input  logic    stall_f,
  input  word_t   branch_targ,
  input  word_t   jump_targ,
  input  word_t   jumpreg_targ,
  output word_t   imem_addr,
  output word_t   pc_f,
  output word_t   pc_plus4_f
);

  word_t pc_next;

  // Next PC mux
  always_comb begin
    case (pc_sel)
      PC_PLUS4:   pc_next = pc_plus4_f;
      PC_BRANCH:  pc_next = branch_targ;
      PC_JUMP:    pc_next = jump_targ;
      PC_JUMPREG: pc_next = jumpreg_targ;
      default:    pc_next = pc_plus4_f;
    endcase
  end

  // Fetch request goes out in P
  assign imem_addr = reset ? RESET_VECTOR : pc_next;

  // F <- P
  always_ff @(posedge clk) begin
    if (reset) begin
      pc_f <= RESET_VECTOR;
    end else if (!stall_f) begin
      pc_f <= pc_next;
    end
  end

  assign pc_plus4_f = pc_f + word_t'(4);

endmodule

// ==== design/decode_stage.sv ====
// D stage. Latches the fetch PC, resolves both source operands through the
// bypass network and forms the ALU operands and the jump/branch targets.

`timescale 1ns/1ps

module decode_stage import dpath_pkg::*; (
  input  logic      clk,
  input  logic      stall_d,
  input  word_t     pc_f,
  input  word_t     pc_plus4_f,
  input  dec_ctrl_t ctrl,
  input  imm_t      fields,
  input  word_t     rdata0,
  input  word_t     rdata1,
  input  byp_src_t  byp,
  output word_t     op0,
  output word_t     op1,
  output word_t     wdata,
  output word_t     pc_d,
  output word_t     branch_targ_d,
  output word_t     jump_targ,
  output word_t     jumpreg_targ
);

  word_t pc_plus4_d;
  word_t rs1_val;
  word_t rs2_val;
  word_t jumpreg_sum;

  // Six-way bypass select, shared by both source ports
  function automatic word_t byp_mux(byp_sel_e sel, word_t rf_val, byp_src_t src);
    word_t val;
    case (sel)
      BYP_RF:  val = rf_val;
      BYP_X:   val = src.x;
      BYP_M:   val = src.m;
      BYP_X2:  val = src.x2;
      BYP_X3:  val = src.x3;
      BYP_W:   val = src.w;
      default: val = rf_val;
    endcase
    return val;
  endfunction

  // ------------------------------------------------------------
  // D <- F
  // ------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (!stall_d) begin
      pc_d       <= pc_f;
      pc_plus4_d <= pc_plus4_f;
    end
  end

  // ------------------------------------------------------------
  // Bypass and operand muxes
  // ------------------------------------------------------------

  assign rs1_val = byp_mux(ctrl.byp0_sel, rdata0, byp);
  assign rs2_val = byp_mux(ctrl.byp1_sel, rdata1, byp);

  // Store data is always the bypassed rs2
  assign wdata = rs2_val;

  always_comb begin
    case (ctrl.op0_sel)
      OP0_RDATA:    op0 = rs1_val;
      OP0_PC:       op0 = pc_d;
      OP0_PC_PLUS4: op0 = pc_plus4_d;
      default:      op0 = '0;
    endcase
  end

  always_comb begin
    case (ctrl.op1_sel)
      OP1_RDATA:  op1 = rs2_val;
      // Shift amount zero-extended
      OP1_SHAMT:  op1 = word_t'(fields.shamt);
      OP1_IMM_U:  op1 = fields.u;
      OP1_IMM_SB: op1 = fields.sb;
      OP1_IMM_I:  op1 = fields.i;
      OP1_IMM_S:  op1 = fields.s;
      default:    op1 = '0;
    endcase
  end

  // ------------------------------------------------------------
  // Target generation
  // ------------------------------------------------------------

  assign branch_targ_d = pc_d + fields.sb;
  assign jump_targ     = pc_d + fields.uj;

  // JALR target with bit 0 cleared
  assign jumpreg_sum  = rs1_val + fields.i;
  assign jumpreg_targ = {jumpreg_sum[XLEN-1:1], 1'b0};

endmodule

// ==== design/alu.sv ====
// X stage ALU. Also produces the six branch-condition flags, which come
// from the subtraction of the two operands.

`timescale 1ns/1ps

module alu import dpath_pkg::*; (
  input  word_t        in0,
  input  word_t        in1,
  input  alu_fn_e      fn,
  output word_t        out,
  output branch_cond_t cond
);

  localparam int unsigned SHW = $clog2(XLEN);

  logic [SHW-1:0] shamt;
  word_t          diff;
  logic           diff_signs;

  assign shamt = in1[SHW-1:0];
  assign diff  = in0 - in1;

  always_comb begin
    case (fn)
      ALU_ADD:  out = in0 + in1;
      ALU_SUB:  out = diff;
      ALU_SLL:  out = in0 << shamt;
      ALU_OR:   out = in0 | in1;
      ALU_SLT:  out = word_t'($signed(in0) < $signed(in1));
      ALU_SLTU: out = word_t'(in0 < in1);
      ALU_AND:  out = in0 & in1;
      ALU_XOR:  out = in0 ^ in1;
      ALU_NOR:  out = ~(in0 | in1);
      ALU_SRL:  out = in0 >> shamt;
      ALU_SRA:  out = word_t'($signed(in0) >>> shamt);
      default:  out = '0;
    endcase
  end

  // ------------------------------------------------------------
  // Branch conditions
  // ------------------------------------------------------------

  // Operands of opposite sign cannot rely on the difference sign
  assign diff_signs = in0[XLEN-1] ^ in1[XLEN-1];

  assign cond.eq  = (diff == '0);
  assign cond.ne  = (diff != '0);
  // Signed: negative operand is the smaller one
  assign cond.lt  = diff_signs ? in0[XLEN-1] : diff[XLEN-1];
  assign cond.ge  = diff_signs ? in1[XLEN-1] : ~diff[XLEN-1];
  // Unsigned: operand with MSB set is the larger one
  assign cond.ltu = diff_signs ? in1[XLEN-1] : diff[XLEN-1];
  assign cond.geu = diff_signs ? in0[XLEN-1] : ~diff[XLEN-1];

endmodule

// ==== design/mem_stage.sv ====
// M stage. Extends the load response, holds the one-entry response queue and
// selects the value handed on toward writeback.

`timescale 1ns/1ps

module mem_stage import dpath_pkg::*; (
  input  logic      clk,
  input  mem_ctrl_t ctrl,
  input  word_t     exec_m,
  input  word_t     resp_data,
  output word_t     wb_m
);

  word_t resp_ext;
  word_t queue_q;
  word_t mem_val;

  // Subword extension
  always_comb begin
    case (ctrl.load_sel)
      LD_W:    resp_ext = resp_data;
      LD_B:    resp_ext = {{24{resp_data[7]}}, resp_data[7:0]};
      LD_BU:   resp_ext = {24'b0, resp_data[7:0]};
      LD_H:    resp_ext = {{16{resp_data[15]}}, resp_data[15:0]};
      LD_HU:   resp_ext = {16'b0, resp_data[15:0]};
      default: resp_ext = resp_data;
    endcase
  end

  // One-entry queue holds an early response
  always_ff @(posedge clk) begin
    if (ctrl.queue_en) begin
      queue_q <= resp_ext;
    end
  end

  // Queued response replaces the live one
  assign mem_val = ctrl.queue_val ? queue_q : resp_ext;

  // Writeback source
  assign wb_m = ctrl.wb_sel ? mem_val : exec_m;

endmodule

// ==== design/core_dpath.sv ====
// Seven-stage scalar datapath top (P F D X M X2 X3 W). All control comes
// from an external controller, timed to the stage each select belongs to.

`timescale 1ns/1ps

module core_dpath import dpath_pkg::*; #(
  parameter word_t RESET_VECTOR = 32'h0008_0000
) (
  input  logic         clk,
  input  logic         reset,
  input  pc_sel_e      pc_sel,
  input  word_t        inst,
  input  dec_ctrl_t    dec_ctrl,
  input  alu_fn_e      alu_fn,
  input  mem_ctrl_t    mem_ctrl,
  input  wb_ctrl_t     wb_ctrl,
  input  stall_t       stall,
  input  word_t        dmem_resp_data,
  output word_t        imem_addr,
  output word_t        dmem_req_addr,
  output word_t        dmem_req_data,
  output word_t        csr_data,
  output branch_cond_t branch_cond
);

  // F and D
  word_t    pc_f;
  word_t    pc_plus4_f;
  word_t    jump_targ;
  word_t    jumpreg_targ;
  imm_t     fields;
  word_t    rf_rdata0;
  word_t    rf_rdata1;
  word_t    op0_d;
  word_t    op1_d;
  word_t    wdata_d;
  word_t    branch_targ_d;
  byp_src_t byp;

  // X through W
  word_t op0_x;
  word_t op1_x;
  word_t wdata_x;
  word_t branch_targ_x;
  word_t alu_out;
  word_t exec_m;
  word_t wb_m;
  word_t wb_x2;
  word_t wb_x3;
  word_t wb_w;

  // ------------------------------------------------------------
  // P, F and D stages
  // ------------------------------------------------------------

  fetch_stage #(
    .RESET_VECTOR (RESET_VECTOR)
  ) u_fetch (
    .clk          (clk),
    .reset        (reset),
    .pc_sel       (pc_sel),
    .stall_f      (stall.f),
    .branch_targ  (branch_targ_x),
    .jump_targ    (jump_targ),
    .jumpreg_targ (jumpreg_targ),
    .imem_addr    (imem_addr),
    .pc_f         (pc_f),
    .pc_plus4_f   (pc_plus4_f)
  );

  inst_fields u_fields (
    .inst   (inst),
    .fields (fields)
  );

  regfile u_regfile (
    .clk    (clk),
    .raddr0 (fields.rs1),
    .rdata0 (rf_rdata0),
    .raddr1 (fields.rs2),
    .rdata1 (rf_rdata1),
    .wen    (wb_ctrl.rf_wen),
    .waddr  (wb_ctrl.rf_waddr),
    .wdata  (wb_w)
  );

  // Forwarding sources, youngest first
  assign byp.x  = alu_out;
  assign byp.m  = wb_m;
  assign byp.x2 = wb_x2;
  assign byp.x3 = wb_x3;
  assign byp.w  = wb_w;

  decode_stage u_decode (
    .clk           (clk),
    .stall_d       (stall.d),
    .pc_f          (pc_f),
    .pc_plus4_f    (pc_plus4_f),
    .ctrl          (dec_ctrl),
    .fields        (fields),
    .rdata0        (rf_rdata0),
    .rdata1        (rf_rdata1),
    .byp           (byp),
    .op0           (op0_d),
    .op1           (op1_d),
    .wdata         (wdata_d),
    .pc_d          (),
    .branch_targ_d (branch_targ_d),
    .jump_targ     (jump_targ),
    .jumpreg_targ  (jumpreg_targ)
  );

  // ------------------------------------------------------------
  // X stage
  // ------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (!stall.x) begin
      op0_x         <= op0_d;
      op1_x         <= op1_d;
      wdata_x       <= wdata_d;
      branch_targ_x <= branch_targ_d;
    end
  end

  alu u_alu (
    .in0  (op0_x),
    .in1  (op1_x),
    .fn   (alu_fn),
    .out  (alu_out),
    .cond (branch_cond)
  );

  // Memory request leaves in X, response returns in M
  assign dmem_req_addr = alu_out;
  assign dmem_req_data = wdata_x;

  // ------------------------------------------------------------
  // M stage
  // ------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (!stall.m) begin
      exec_m <= alu_out;
    end
  end

  mem_stage u_mem (
    .clk       (clk),
    .ctrl      (mem_ctrl),
    .exec_m    (exec_m),
    .resp_data (dmem_resp_data),
    .wb_m      (wb_m)
  );

  // ------------------------------------------------------------
  // X2, X3 and W
  // ------------------------------------------------------------

  // Result only carried along past M
  always_ff @(posedge clk) begin
    if (!stall.x2) begin
      wb_x2 <= wb_m;
    end
    if (!stall.x3) begin
      wb_x3 <= wb_x2;
    end
    if (!stall.w) begin
      wb_w <= wb_x3;
    end
  end

  // W value doubles as CSR write data
  assign csr_data = wb_w;

endmodule

// ==== tb/dpath_checker.sv ====
// Scoreboard for the datapath testbench. Holds the reference models, keeps
// cycle-tagged expected values and compares them on the falling clock edge.

`timescale 1ns/1ps

module dpath_checker import dpath_pkg::*; (
  input logic         clk,
  input word_t        imem_addr,
  input word_t        dmem_req_addr,
  input word_t        dmem_req_data,
  input word_t        csr_data,
  input branch_cond_t branch_cond
);

  localparam int K_IMEM = 0;
  localparam int K_ADDR = 1;
  localparam int K_DATA = 2;
  localparam int K_CSR  = 3;
  localparam int K_COND = 4;

  // Cycle index, bumped on every rising edge
  int cyc = 0;
  int total_checks = 0;
  int total_errors = 0;
  int test_checks = 0;
  int test_errors = 0;
  int tests_run = 0;
  string test_name = "none";

  // Expected values, one entry per check
  int    exp_cyc[$];
  int    exp_kind[$];
  word_t exp_val[$];

  always @(posedge clk) begin
    cyc <= cyc + 1;
  end

  // ------------------------------------------------------------
  // Reference models
  // ------------------------------------------------------------

  function automatic word_t ref_alu(alu_fn_e fn, word_t a, word_t b);
    int unsigned s;
    word_t r;
    s = b[4:0];
    case (fn)
      ALU_ADD:  r = a + b;
      ALU_SUB:  r = a - b;
      ALU_SLL:  r = a << s;
      ALU_OR:   r = a | b;
      // Sign bits differ, so the negative one is smaller
      ALU_SLT:  r = (a[31] != b[31]) ? word_t'(a[31]) : word_t'(a < b);
      ALU_SLTU: r = word_t'(a < b);
      ALU_AND:  r = a & b;
      ALU_XOR:  r = a ^ b;
      ALU_NOR:  r = ~(a | b);
      ALU_SRL:  r = a >> s;
      ALU_SRA:  r = (a >> s) | (a[31] ? ~(32'hffff_ffff >> s) : 32'h0);
      default:  r = '0;
    endcase
    return r;
  endfunction

  function automatic branch_cond_t ref_cond(word_t a, word_t b);
    branch_cond_t c;
    c.eq  = (a == b);
    c.ne  = (a != b);
    c.lt  = ($signed(a) < $signed(b));
    c.ltu = (a < b);
    c.ge  = !c.lt;
    c.geu = !c.ltu;
    return c;
  endfunction

  function automatic word_t ref_ext(load_sel_e sel, word_t d);
    logic signed [7:0]  b8;
    logic signed [15:0] h16;
    int v;
    b8  = d[7:0];
    h16 = d[15:0];
    case (sel)
      LD_B:    v = b8;
      LD_BU:   v = d[7:0];
      LD_H:    v = h16;
      LD_HU:   v = d[15:0];
      default: v = d;
    endcase
    return word_t'(v);
  endfunction

  function automatic word_t ref_imm_i(word_t w);
    logic signed [11:0] t;
    int v;
    t = w[31:20];
    v = t;
    return word_t'(v);
  endfunction

  function automatic word_t ref_imm_sb(word_t w);
    logic signed [12:0] t;
    int v;
    t = {w[31], w[7], w[30:25], w[11:8], 1'b0};
    v = t;
    return word_t'(v);
  endfunction

  function automatic word_t ref_imm_uj(word_t w);
    logic signed [20:0] t;
    int v;
    t = {w[31], w[19:12], w[20], w[30:21], 1'b0};
    v = t;
    return word_t'(v);
  endfunction

  // ------------------------------------------------------------
  // Comparison
  // ------------------------------------------------------------

  function automatic string kind_name(int k);
    case (k)
      K_IMEM:  return "imem_addr";
      K_ADDR:  return "dmem_req_addr";
      K_DATA:  return "dmem_req_data";
      K_CSR:   return "csr_data";
      default: return "branch_cond";
    endcase
  endfunction

  function automatic word_t actual_of(int k);
    case (k)
      K_IMEM:  return imem_addr;
      K_ADDR:  return dmem_req_addr;
      K_DATA:  return dmem_req_data;
      K_CSR:   return csr_data;
      default: return word_t'(branch_cond);
    endcase
  endfunction

  task automatic expect_at(int c, int kind, word_t v);
    exp_cyc.push_back(c);
    exp_kind.push_back(kind);
    exp_val.push_back(v);
  endtask

  // Outputs are settled by the falling edge
  always @(negedge clk) begin : compare_outputs
    word_t act;
    for (int i = exp_cyc.size() - 1; i >= 0; i--) begin
      if (exp_cyc[i] == cyc) begin
        act = actual_of(exp_kind[i]);
        test_checks++;
        total_checks++;
        if (act !== exp_val[i]) begin
          $display("** Error %s: %s cycle %0d expected %h actual %h", test_name,
                   kind_name(exp_kind[i]), cyc, exp_val[i], act);
          test_errors++;
          total_errors++;
        end
        exp_cyc.delete(i);
        exp_kind.delete(i);
        exp_val.delete(i);
      end
    end
  end

  task automatic start_test(string name);
    test_name   = name;
    test_checks = 0;
    test_errors = 0;
  endtask

  task automatic finish_test();
    // Leftovers mean the run never reached the tagged cycle
    foreach (exp_cyc[i]) begin
      $display("%s: check of %s for cycle %0d never ran", test_name,
               kind_name(exp_kind[i]), exp_cyc[i]);
      test_errors++;
      total_errors++;
    end
    exp_cyc.delete();
    exp_kind.delete();
    exp_val.delete();
    tests_run++;
    $display("Test %-14s %0d checks, %0d errors, %s", test_name, test_checks,
             test_errors, (test_errors == 0) ? "ok" : "mismatch");
  endtask

  task automatic report_summary();
    $display("Summary: %0d tests, %0d checks, %0d errors", tests_run,
             total_checks, total_errors);
  endtask

endmodule

// ==== tb/tb_core_dpath.sv ====
// Top-level testbench for the scalar datapath. Plays the external controller
// cycle by cycle and hands expected values to the checker.

`timescale 1ns/1ps

module tb_core_dpath import dpath_pkg::*; ();

  localparam word_t RV       = 32'h0008_0000;
  localparam int    N_TESTS  = 6;
  localparam int    MAX_CYC  = 40;
  localparam int    WATCHDOG = N_TESTS * MAX_CYC * 10 * 2;
  localparam int    SLOTS    = 512;

  logic         clk = 1'b0;
  logic         reset;
  pc_sel_e      pc_sel;
  word_t        inst;
  dec_ctrl_t    dec_ctrl;
  alu_fn_e      alu_fn;
  mem_ctrl_t    mem_ctrl;
  wb_ctrl_t     wb_ctrl;
  stall_t       stall;
  word_t        dmem_resp_data;
  word_t        imem_addr;
  word_t        dmem_req_addr;
  word_t        dmem_req_data;
  word_t        csr_data;
  branch_cond_t branch_cond;

  // Later-stage controls indexed by cycle
  alu_fn_e   fn_s   [SLOTS];
  mem_ctrl_t mem_s  [SLOTS];
  wb_ctrl_t  wb_s   [SLOTS];
  word_t     resp_s [SLOTS];

  // PC model of the F and D registers and the next PC
  word_t pc_f_m;
  word_t pc_d_m;
  word_t next_m;

  localparam dec_ctrl_t BUBBLE = '{OP0_ZERO, OP1_ZERO, BYP_RF, BYP_RF};
  localparam mem_ctrl_t MC_EXEC = '{LD_W, 1'b0, 1'b0, 1'b0};
  // Disabled write still names a live register
  localparam wb_ctrl_t  NO_WB = '{1'b0, 5'd1};

  always #5 clk = ~clk;

  core_dpath #(
    .RESET_VECTOR (RV)
  ) DUT (
    .clk            (clk),
    .reset          (reset),
    .pc_sel         (pc_sel),
    .inst           (inst),
    .dec_ctrl       (dec_ctrl),
    .alu_fn         (alu_fn),
    .mem_ctrl       (mem_ctrl),
    .wb_ctrl        (wb_ctrl),
    .stall          (stall),
    .dmem_resp_data (dmem_resp_data),
    .imem_addr      (imem_addr),
    .dmem_req_addr  (dmem_req_addr),
    .dmem_req_data  (dmem_req_data),
    .csr_data       (csr_data),
    .branch_cond    (branch_cond)
  );

  dpath_checker chk (
    .clk           (clk),
    .imem_addr     (imem_addr),
    .dmem_req_addr (dmem_req_addr),
    .dmem_req_data (dmem_req_data),
    .csr_data      (csr_data),
    .branch_cond   (branch_cond)
  );

  // ------------------------------------------------------------
  // Cycle driver
  // ------------------------------------------------------------

  task automatic apply_cycle();
    int c;
    c = chk.cyc % SLOTS;
    alu_fn         = fn_s[c];
    mem_ctrl       = mem_s[c];
    wb_ctrl        = wb_s[c];
    dmem_resp_data = resp_s[c];
    fn_s[c]   = ALU_ADD;
    mem_s[c]  = MC_EXEC;
    wb_s[c]   = NO_WB;
    resp_s[c] = '0;
    // D stage idles unless a test issues
    inst     = '0;
    dec_ctrl = BUBBLE;
    pc_sel   = PC_PLUS4;
    pc_d_m   = pc_f_m;
    pc_f_m   = next_m;
    next_m   = pc_f_m + 4;
  endtask

  task automatic next_cycle();
    @(posedge clk);
    #1;
    apply_cycle();
  endtask

  task automatic idle(int n);
    repeat (n) next_cycle();
  endtask

  // Redirect the PC this cycle and check the fetch address
  task automatic set_pc(pc_sel_e sel, word_t targ);
    pc_sel = sel;
    next_m = targ;
    chk.expect_at(chk.cyc, chk.K_IMEM, targ);
  endtask

  // Present one instruction in D and schedule its later-stage controls
  task automatic issue(word_t w, dec_ctrl_t dc, alu_fn_e fn, mem_ctrl_t mc,
                       word_t resp, wb_ctrl_t wc);
    int k;
    k = chk.cyc;
    inst     = w;
    dec_ctrl = dc;
    fn_s[(k + 1) % SLOTS]   = fn;
    mem_s[(k + 2) % SLOTS]  = mc;
    resp_s[(k + 2) % SLOTS] = resp;
    wb_s[(k + 5) % SLOTS]   = wc;
  endtask

  task automatic load_word(word_t v, load_sel_e sel, wb_ctrl_t wc);
    issue('0, BUBBLE, ALU_ADD, '{sel, 1'b0, 1'b0, 1'b1}, v, wc);
    chk.expect_at(chk.cyc + 5, chk.K_CSR, chk.ref_ext(sel, v));
    next_cycle();
  endtask

  // Register-register op through the register file
  task automatic rr_op(alu_fn_e fn, reg_addr_t rs1, reg_addr_t rs2, word_t a, word_t b);
    word_t r;
    r = chk.ref_alu(fn, a, b);
    issue({7'b0, rs2, rs1, 15'b0}, '{OP0_RDATA, OP1_RDATA, BYP_RF, BYP_RF}, fn,
          MC_EXEC, '0, NO_WB);
    chk.expect_at(chk.cyc + 1, chk.K_ADDR, r);
    chk.expect_at(chk.cyc + 1, chk.K_DATA, b);
    chk.expect_at(chk.cyc + 5, chk.K_CSR, r);
    next_cycle();
  endtask

  // Operand pair via two loads then SUB with X2 and M bypass
  task automatic compare_pair(word_t a, word_t b);
    load_word(a, LD_W, NO_WB);
    load_word(b, LD_W, NO_WB);
    idle(1);
    issue('0, '{OP0_RDATA, OP1_RDATA, BYP_X2, BYP_M}, ALU_SUB, MC_EXEC, '0, NO_WB);
    chk.expect_at(chk.cyc + 1, chk.K_COND, word_t'(chk.ref_cond(a, b)));
    chk.expect_at(chk.cyc + 1, chk.K_ADDR, a - b);
    next_cycle();
  endtask

  // ------------------------------------------------------------
  // Test sequences
  // ------------------------------------------------------------

  initial begin : main_sequence
    word_t w;
    word_t a;
    word_t b;
    word_t base;
    word_t targ;
    word_t vals[3];
    alu_fn_e fn;
    void'($urandom(32'ha14e));
    reset = 1'b1;
    pc_sel = PC_PLUS4;
    inst = '0;
    dec_ctrl = BUBBLE;
    alu_fn = ALU_ADD;
    mem_ctrl = MC_EXEC;
    wb_ctrl = NO_WB;
    stall = '0;
    dmem_resp_data = '0;
    for (int i = 0; i < SLOTS; i++) begin
      fn_s[i] = ALU_ADD;
      mem_s[i] = MC_EXEC;
      wb_s[i] = NO_WB;
      resp_s[i] = '0;
    end
    pc_f_m = RV;
    next_m = RV;

    chk.start_test("reset_fetch");
    chk.expect_at(1, chk.K_IMEM, RV);
    repeat (2) @(posedge clk);
    #1;
    reset = 1'b0;
    apply_cycle();
    repeat (8) begin
      set_pc(PC_PLUS4, pc_f_m + 4);
      next_cycle();
    end
    chk.finish_test();

    chk.start_test("jumps");
    repeat (3) begin
      w = $urandom();
      inst = w;
      set_pc(PC_JUMP, pc_d_m + chk.ref_imm_uj(w));
      next_cycle();
      // rs1 comes from a load sitting in M
      base = $urandom();
      load_word(base, LD_W, NO_WB);
      idle(1);
      w = $urandom();
      inst = w;
      dec_ctrl = '{OP0_ZERO, OP1_ZERO, BYP_M, BYP_RF};
      targ = (base + chk.ref_imm_i(w)) & 32'hffff_fffe;
      set_pc(PC_JUMPREG, targ);
      next_cycle();
      w = $urandom();
      inst = w;
      targ = pc_d_m + chk.ref_imm_sb(w);
      next_cycle();
      set_pc(PC_BRANCH, targ);
      next_cycle();
    end
    idle(2);
    chk.finish_test();

    chk.start_test("alu_pipeline");
    repeat (2) begin
      a = $urandom();
      b = $urandom();
      load_word(a, LD_W, '{1'b1, 5'd1});
      load_word(b, LD_W, '{1'b1, 5'd2});
      idle(5);
      repeat (4) begin
        fn = alu_fn_e'($urandom() % 11);
        rr_op(fn, 5'd1, 5'd2, a, b);
      end
    end
    repeat (4) begin
      w = $urandom();
      fn = alu_fn_e'($urandom() % 11);
      b = chk.ref_alu(fn, '0, chk.ref_imm_i(w));
      issue(w, '{OP0_ZERO, OP1_IMM_I, BYP_RF, BYP_RF}, fn, MC_EXEC, '0, NO_WB);
      chk.expect_at(chk.cyc + 1, chk.K_ADDR, b);
      chk.expect_at(chk.cyc + 5, chk.K_CSR, b);
      next_cycle();
    end
    idle(7);
    chk.finish_test();

    chk.start_test("regfile_bypass");
    for (int r = 0; r < 3; r++) begin
      vals[r] = $urandom();
      load_word(vals[r], LD_W, '{1'b1, reg_addr_t'(r + 3)});
    end
    idle(5);
    for (int r = 0; r < 3; r++) begin
      rr_op(ALU_ADD, reg_addr_t'(r + 3), 5'd0, vals[r], '0);
    end
    // Dependent op d cycles behind its producer
    for (int d = 1; d <= 5; d++) begin
      w = $urandom();
      base = chk.ref_imm_i(w);
      issue(w, '{OP0_ZERO, OP1_IMM_I, BYP_RF, BYP_RF}, ALU_ADD, MC_EXEC, '0, NO_WB);
      chk.expect_at(chk.cyc + 5, chk.K_CSR, base);
      next_cycle();
      idle(d - 1);
      w = $urandom();
      a = base + chk.ref_imm_i(w);
      issue(w, '{OP0_RDATA, OP1_IMM_I, byp_sel_e'(d), BYP_RF}, ALU_ADD, MC_EXEC, '0,
            NO_WB);
      chk.expect_at(chk.cyc + 1, chk.K_ADDR, a);
      chk.expect_at(chk.cyc + 5, chk.K_CSR, a);
      next_cycle();
    end
    idle(7);
    chk.finish_test();

    chk.start_test("loads");
    for (int s = 0; s < 5; s++) begin
      load_word($urandom(), load_sel_e'(s), NO_WB);
    end
    // Capture a byte load and replay it two cycles later over a live halfword
    a = $urandom();
    issue('0, BUBBLE, ALU_ADD, '{LD_B, 1'b1, 1'b0, 1'b1}, a, NO_WB);
    chk.expect_at(chk.cyc + 5, chk.K_CSR, chk.ref_ext(LD_B, a));
    next_cycle();
    // Live load in between leaves the queue alone
    load_word(~a, LD_W, NO_WB);
    issue('0, BUBBLE, ALU_ADD, '{LD_HU, 1'b0, 1'b1, 1'b1}, ~a, NO_WB);
    chk.expect_at(chk.cyc + 5, chk.K_CSR, chk.ref_ext(LD_B, a));
    next_cycle();
    idle(7);
    chk.finish_test();

    chk.start_test("branch_flags");
    compare_pair(32'h0, 32'h0);
    compare_pair(32'h8000_0000, 32'h7fff_ffff);
    compare_pair(32'h7fff_ffff, 32'h8000_0000);
    compare_pair(32'hffff_ffff, 32'h1);
    compare_pair(32'h1, 32'hffff_ffff);
    compare_pair(32'h8000_0000, 32'h8000_0000);
    compare_pair($urandom(), $urandom());
    compare_pair($urandom(), $urandom());
    idle(7);
    chk.finish_test();

    chk.report_summary();
    if (chk.total_errors == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

  initial begin : watchdog
    #(WATCHDOG);
    $display("Watchdog expired after %0d ns before all tests completed", WATCHDOG);
    $display("Testbench failed");
    $finish;
  end

endmodule

// ==== build.f ====
design/dpath_pkg.sv
design/inst_fields.sv
design/regfile.sv
design/fetch_stage.sv
design/decode_stage.sv
design/alu.sv
design/mem_stage.sv
design/core_dpath.sv
tb/dpath_checker.sv
tb/tb_core_dpath.sv

// ==== Bender.yml ====
package:
  name: core_dpath

sources:
  - design/dpath_pkg.sv
  - design/inst_fields.sv
  - design/regfile.sv
  - design/fetch_stage.sv
  - design/decode_stage.sv
  - design/alu.sv
  - design/mem_stage.sv
  - design/core_dpath.sv
  - target: simulation
    files:
      - tb/dpath_checker.sv
      - tb/tb_core_dpath.sv
